/* graphicsCommandProcessor.f */
+incdir+include
verilog/gpPkg.sv
verilog/cmdFetch.sv
verilog/cmdUnpack.sv
verilog/cmdDecode.sv
verilog/engineDispatch.sv
verilog/graphicsCommandProcessor.sv
tb/gcpTbModels.sv
tb/gcpTb.sv

/* include/gp_consts.svh */
`ifndef GP_CONSTS_SVH
`define GP_CONSTS_SVH

// opcodes live in the top byte of a command word
`define GP_OP_STOP 8'd0
`define GP_OP_FILL 8'd1
`define GP_OP_LINE 8'd2

// beat slots in the unpack buffer, also the fetch credit pool
`define GP_BEAT_DEPTH 4

// credits each engine grants at reset
`define GP_LE_CREDITS 2
`define GP_FF_CREDITS 2

// dispatch queue entries, decode starts with one credit per entry
`define GP_SLOT_CREDITS 2

`define GP_ADDR_STEP 8

`endif

/* tb/gcpTb.sv */
`include "gp_consts.svh"

module gcpTb;
	import gpPkg::*;

	localparam int MaxRows = 8;
	localparam int MaxWords = 24;
	localparam int MaxCmds = 12;
	localparam int RowSpan = 32; // word address gap between stored lists
	localparam int Seed = 32'h652139e3;

	logic         clk;
	logic         rst;
	logic         start;
	logic [30:0]  cmdAddr;
	logic [31:0]  frameBase;
	logic         busy;
	logic         reqValid;
	logic [30:0]  reqAddr;
	logic         reqFull;
	logic         rdValid;
	logic [127:0] rdData;
	logic         leValid;
	lineCmd_t     leCmd;
	logic         leCredit;
	logic         ffValid;
	fillCmd_t     ffCmd;
	logic         ffCredit;
	logic         leOverrun;
	logic         ffOverrun;

	string       testName [MaxRows];
	logic [31:0] frameOf [MaxRows];
	bit          restartMid [MaxRows]; // second start while busy
	int          listLen [MaxRows];
	logic [31:0] listWords [MaxRows][MaxWords];
	int          nFill [MaxRows];
	int          nLine [MaxRows];
	int          nCmd [MaxRows];
	fillCmd_t    expFill [MaxRows][MaxCmds];
	lineCmd_t    expLine [MaxRows][MaxCmds];
	bit          expIsLine [MaxRows][2*MaxCmds]; // engine of each command in list order
	int          nRows = 0;
	int          cycles = 0;
	int          cycleLimit = 0;
	fillCmd_t    gotFill [$];
	lineCmd_t    gotLine [$];
	bit          gotIsLine [$];

	graphicsCommandProcessor DUT (.*);
	dramModel #(.Seed(Seed)) DRAM (.*);
	engineModel #(.Credits(`GP_LE_CREDITS), .Seed(Seed)) lineEngine (
		.clk, .rst, .cmdValid(leValid), .credit(leCredit), .overrun(leOverrun));
	engineModel #(.Credits(`GP_FF_CREDITS), .Seed(Seed)) fillEngine (
		.clk, .rst, .cmdValid(ffValid), .credit(ffCredit), .overrun(ffOverrun));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	// commands handed to the engines, in arrival order
	always @(negedge clk) begin
		if (!rst) begin
			if (ffValid) begin
				gotFill.push_back(ffCmd);
				gotIsLine.push_back(1'b0);
			end
			if (leValid) begin
				gotLine.push_back(leCmd);
				gotIsLine.push_back(1'b1);
			end
			if (leOverrun)
				abortRun("line engine got more commands than it had credits");
			if (ffOverrun)
				abortRun("frame filler got more commands than it had credits");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit)
			abortRun($sformatf("timeout, the tests did not finish in %0d cycles", cycleLimit));
	end

	function automatic logic [31:0] opWord(logic [7:0] op, logic [23:0] color);
		return {op, color};
	endfunction

	function automatic logic [31:0] ptWord(logic [9:0] x, logic [9:0] y);
		return {6'h2A, x, 6'h15, y}; // padding bits set on purpose
	endfunction

	task automatic newRow(string name, logic [31:0] frame, bit restart);
		testName[nRows] = name;
		frameOf[nRows] = frame;
		restartMid[nRows] = restart;
		listLen[nRows] = 0;
		nFill[nRows] = 0;
		nLine[nRows] = 0;
		nCmd[nRows] = 0;
		nRows++;
	endtask

	task automatic addWord(logic [31:0] w);
		listWords[nRows - 1][listLen[nRows - 1]] = w;
		listLen[nRows - 1]++;
	endtask

	task automatic expectFill(logic [23:0] color);
		int r;
		r = nRows - 1;
		expFill[r][nFill[r]] = '{color: color, frame: frameOf[r]};
		nFill[r]++;
		expIsLine[r][nCmd[r]] = 1'b0;
		nCmd[r]++;
	endtask

	task automatic expectLine(logic [23:0] color, logic [9:0] x0, logic [9:0] y0,
			logic [9:0] x1, logic [9:0] y1);
		int r;
		r = nRows - 1;
		expLine[r][nLine[r]] = '{color: color, x0: x0, y0: y0, x1: x1, y1: y1,
			frame: frameOf[r]};
		nLine[r]++;
		expIsLine[r][nCmd[r]] = 1'b1;
		nCmd[r]++;
	endtask

	task automatic buildTable();
		int total;
		total = 0;
		newRow("fillStop", 32'h1000_0000, 1'b0);
		addWord(opWord(`GP_OP_FILL, 24'h123456));
		addWord(opWord(`GP_OP_STOP, 24'h0));
		expectFill(24'h123456);

		newRow("oneLine", 32'h2000_0400, 1'b0);
		addWord(opWord(`GP_OP_LINE, 24'hABCDEF));
		addWord(ptWord(10'd17, 10'd300));
		addWord(ptWord(10'd1023, 10'd0));
		addWord(opWord(`GP_OP_STOP, 24'h0));
		expectLine(24'hABCDEF, 10'd17, 10'd300, 10'd1023, 10'd0);

		// second line's last point sits in the next block
		newRow("crossBlock", 32'h3000_0000, 1'b0);
		addWord(opWord(`GP_OP_FILL, 24'h000011));
		addWord(opWord(`GP_OP_LINE, 24'h220022));
		addWord(ptWord(10'd1, 10'd2));
		addWord(ptWord(10'd3, 10'd4));
		addWord(opWord(`GP_OP_FILL, 24'h330033));
		addWord(opWord(`GP_OP_FILL, 24'h440044));
		addWord(opWord(`GP_OP_LINE, 24'h550055));
		addWord(ptWord(10'd100, 10'd200));
		addWord(ptWord(10'd300, 10'd400));
		addWord(opWord(`GP_OP_FILL, 24'h660066));
		addWord(opWord(`GP_OP_STOP, 24'h0));
		expectFill(24'h000011);
		expectLine(24'h220022, 10'd1, 10'd2, 10'd3, 10'd4);
		expectFill(24'h330033);
		expectFill(24'h440044);
		expectLine(24'h550055, 10'd100, 10'd200, 10'd300, 10'd400);
		expectFill(24'h660066);

		// back to back fills run the filler out of credits
		newRow("backPressure", 32'h4000_1000, 1'b1);
		for (int k = 0; k < 4; k++) begin
			addWord(opWord(`GP_OP_FILL, 24'h0A0000 | 24'(k)));
			addWord(opWord(`GP_OP_FILL, 24'h0C0000 | 24'(k)));
			addWord(opWord(`GP_OP_LINE, 24'h0B0000 | 24'(k)));
			addWord(ptWord(10'(k * 7), 10'(k * 9)));
			addWord(ptWord(10'(1000 - k), 10'(500 + k)));
			expectFill(24'h0A0000 | 24'(k));
			expectFill(24'h0C0000 | 24'(k));
			expectLine(24'h0B0000 | 24'(k), 10'(k * 7), 10'(k * 9), 10'(1000 - k),
				10'(500 + k));
		end
		addWord(opWord(`GP_OP_STOP, 24'h0));
		addWord(opWord(`GP_OP_FILL, 24'hBAD001)); // behind the stop
		addWord(opWord(`GP_OP_LINE, 24'hBAD002));

		newRow("skipUnknown", 32'h5000_0000, 1'b0);
		addWord(opWord(8'h7F, 24'h111111));
		addWord(opWord(`GP_OP_FILL, 24'h777777));
		addWord(opWord(8'hFF, 24'hFFFFFF));
		addWord(opWord(8'h03, 24'h123456));
		addWord(opWord(`GP_OP_LINE, 24'h888888));
		addWord(ptWord(10'd5, 10'd6));
		addWord(ptWord(10'd7, 10'd8));
		addWord(opWord(8'h80, 24'h0));
		addWord(opWord(`GP_OP_STOP, 24'h0));
		addWord(opWord(`GP_OP_FILL, 24'h999999));
		addWord(opWord(`GP_OP_LINE, 24'hAAAAAA));
		addWord(ptWord(10'd9, 10'd10));
		addWord(ptWord(10'd11, 10'd12));
		expectFill(24'h777777);
		expectLine(24'h888888, 10'd5, 10'd6, 10'd7, 10'd8);

		for (int r = 0; r < nRows; r++)
			total += listLen[r];
		cycleLimit = 200 * total;
	endtask

	task automatic checkCount(string name, string what, int exp, int act);
		if (act != exp)
			abortRun($sformatf("FAIL %s %s: expected %0d, actual %0d", name, what, exp, act));
	endtask

	task automatic checkAddr(string name, logic [30:0] exp, logic [30:0] act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s request address: expected %h, actual %h",
				name, exp, act));
	endtask

	task automatic checkFill(string name, int idx, fillCmd_t exp, fillCmd_t act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s fill %0d: expected %h, actual %h", name, idx, exp, act));
	endtask

	task automatic checkLine(string name, int idx, lineCmd_t exp, lineCmd_t act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s line %0d: expected %h, actual %h", name, idx, exp, act));
	endtask

	task automatic checkOrder(string name, int idx, bit exp, bit act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s command %0d: expected %s, actual %s", name, idx,
				exp ? "line" : "fill", act ? "line" : "fill"));
	endtask

	task automatic runTest(int r);
		string name;
		name = testName[r];
		for (int i = 0; i < listLen[r]; i++)
			DRAM.writeWord(31'(r * RowSpan + i), listWords[r][i]);
		gotFill.delete();
		gotLine.delete();
		gotIsLine.delete();
		@(posedge clk);
		start <= 1'b1;
		cmdAddr <= 31'(r * RowSpan);
		frameBase <= frameOf[r];
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		if (!busy)
			abortRun($sformatf("%s: busy did not rise after start", name));
		if (!reqValid)
			abortRun($sformatf("%s: no block request one cycle after start", name));
		checkAddr(name, 31'(r * RowSpan), reqAddr);
		if (restartMid[r]) begin
			@(posedge clk);
			start <= 1'b1; // points at the first list with another frame
			cmdAddr <= 31'd0;
			frameBase <= 32'hDEAD_BEEF;
			@(posedge clk);
			start <= 1'b0;
			@(negedge clk);
		end
		while (busy)
			@(negedge clk);
		repeat (20) @(negedge clk); // nothing may trail the end of a run
		checkCount(name, "fill count", nFill[r], gotFill.size());
		checkCount(name, "line count", nLine[r], gotLine.size());
		for (int i = 0; i < nFill[r]; i++)
			checkFill(name, i, expFill[r][i], gotFill[i]);
		for (int i = 0; i < nLine[r]; i++)
			checkLine(name, i, expLine[r][i], gotLine[i]);
		for (int i = 0; i < nCmd[r]; i++)
			checkOrder(name, i, expIsLine[r][i], gotIsLine[i]);
		$display("%s: %0d fills and %0d lines matched", name, nFill[r], nLine[r]);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		cmdAddr = '0;
		frameBase = '0;
		buildTable();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < nRows; r++)
			runTest(r);
		$display("Verification passed");
		$finish;
	end
endmodule

/* tb/gcpTbModels.sv */
// DRAM with random request stalls, each block comes back as two beats
module dramModel #(
	parameter int Seed = 0
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         reqValid,
	input  logic [30:0]  reqAddr,
	output logic         reqFull,
	output logic         rdValid,
	output logic [127:0] rdData
);
	logic [31:0] mem [256];
	logic [30:0] beatAddr [$]; // word address of each pending beat
	int          beatDue [$];
	int          seed;
	int          now;
	int          due;          // latest scheduled beat, keeps beats in order
	int          delay;

	function automatic logic [127:0] readBeat(logic [30:0] addr);
		logic [7:0] a;
		a = addr[7:0];
		return {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]}; // low word first
	endfunction

	task automatic writeWord(logic [30:0] addr, logic [31:0] data);
		mem[addr[7:0]] = data;
	endtask

	initial begin
		seed = Seed;
		now = 0;
		due = 0;
		reqFull = 1'b0;
		rdValid = 1'b0;
		rdData = '0;
		// unknown opcode 0xE5, rest of the word follows the address
		for (int i = 0; i < 256; i++)
			mem[i] = {8'hE5, 8'(i), 8'hC3, ~8'(i)};
	end

	always @(posedge clk) begin
		rdValid <= 1'b0;
		if (rst) begin
			reqFull <= 1'b0;
			beatAddr.delete();
			beatDue.delete();
		end else begin
			if (beatDue.size() != 0 && beatDue[0] <= now) begin
				rdValid <= 1'b1;
				rdData <= readBeat(beatAddr.pop_front());
				void'(beatDue.pop_front());
			end
			if (reqValid && !reqFull) begin
				for (int b = 0; b < 2; b++) begin
					delay = 1 + int'($unsigned($random(seed)) % 6);
					due = (now + delay > due) ? now + delay : due + 1;
					beatDue.push_back(due);
					beatAddr.push_back(reqAddr + 31'(4 * b));
				end
			end
			reqFull <= ($random(seed) & 3) == 0; // stalls about one cycle in four
		end
		now++;
	end
endmodule

// engine that hands each credit back 1 to 8 cycles after its command
module engineModel #(
	parameter int Credits = 2,
	parameter int Seed = 0
) (
	input  logic clk,
	input  logic rst,
	input  logic cmdValid,
	output logic credit,
	output logic overrun
);
	int returnAt [$]; // cycle at which each held command frees its credit
	int seed;
	int now;
	int inFlight;
	int idx;

	initial begin
		seed = Seed;
		now = 0;
		inFlight = 0;
		credit = 1'b0;
		overrun = 1'b0;
	end

	always @(posedge clk) begin
		credit <= 1'b0;
		if (rst) begin
			returnAt.delete();
			inFlight = 0;
		end else begin
			if (cmdValid) begin
				inFlight++;
				if (inFlight > Credits)
					overrun <= 1'b1;
				returnAt.push_back(now + 1 + int'($unsigned($random(seed)) % 8));
			end
			idx = -1;
			foreach (returnAt[i])
				if (idx < 0 && returnAt[i] <= now)
					idx = i;
			if (idx >= 0) begin // at most one pulse per cycle
				credit <= 1'b1;
				returnAt.delete(idx);
				inFlight--;
			end
		end
		now++;
	end
endmodule

/* verilog/cmdDecode.sv */
`include "gp_consts.svh"

module cmdDecode (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  logic [31:0]     frameBase,
	input  logic            wordValid,
	input  gpPkg::cmdWord_u word,
	input  logic            slotCredit,
	output logic            wordTaken,
	output logic            halt,
	output logic            lineValid,
	output gpPkg::lineCmd_t lineCmd,
	output logic            fillValid,
	output gpPkg::fillCmd_t fillCmd
);
	typedef enum logic [1:0] {
		stOpcode,
		stPoint0,
		stPoint1
	} decodeState_t;

	decodeState_t state;
	logic [1:0]   credits; // free dispatch queue entries
	logic [31:0]  frame;
	logic [23:0]  color;   // line colour held across its point words
	logic [9:0]   x0;
	logic [9:0]   y0;
	logic [7:0]   op;
	logic         spend;

	assign op = word.fill.op;
	assign wordTaken = wordValid && (credits != 2'd0);
	assign halt = wordTaken && (state == stOpcode) && (op == `GP_OP_STOP);
	// a credit goes with the word that completes a command
	assign spend = wordTaken &&
		(((state == stOpcode) && (op == `GP_OP_FILL)) || (state == stPoint1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stOpcode;
			fillValid <= 1'b0;
			lineValid <= 1'b0;
			credits <= 2'(`GP_SLOT_CREDITS);
		end else begin
			fillValid <= 1'b0;
			lineValid <= 1'b0;
			credits <= credits + {1'b0, slotCredit} - {1'b0, spend};
			if (wordTaken) begin
				case (state)
					stOpcode: begin
						if (op == `GP_OP_FILL)
							fillValid <= 1'b1;
						else if (op == `GP_OP_LINE)
							state <= stPoint0;
						// stop and unknown opcodes stay here
					end
					stPoint0: state <= stPoint1;
					stPoint1: begin
						state <= stOpcode;
						lineValid <= 1'b1;
					end
					default: state <= stOpcode;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			frame <= frameBase;
		if (wordTaken) begin
			case (state)
				stOpcode: begin
					color <= word.fill.color;
					fillCmd <= '{color: word.fill.color, frame: frame};
				end
				stPoint0: begin
					x0 <= word.point.x;
					y0 <= word.point.y;
				end
				stPoint1: begin
					lineCmd <= '{color: color, x0: x0, y0: y0,
						x1: word.point.x, y1: word.point.y, frame: frame};
				end
				default: ;
			endcase
		end
	end

	oneEngine: assert property (@(posedge clk) disable iff (rst)
		!(lineValid && fillValid))
		else $error("line and fill issued in the same cycle");

endmodule

/* verilog/cmdFetch.sv */
`include "gp_consts.svh"

module cmdFetch (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic [30:0] cmdAddr,
	input  logic        reqFull,
	input  logic        rdValid,
	input  logic        beatCredit,
	input  logic        halt,
	input  logic        done,
	output logic        reqValid,
	output logic [30:0] reqAddr,
	output logic        drained,
	output logic        busy
);
	logic [2:0] credits;     // free beat slots in cmdUnpack
	logic [2:0] outstanding; // beats requested, not yet returned
	logic       haltSeen;
	logic       startIdle;
	logic       reqAccept;
	logic       canIssue;

	assign startIdle = start && !busy; // start while busy is ignored
	assign reqAccept = reqValid && !reqFull;
	// one block needs two beat slots
	assign canIssue = busy && !haltSeen && !halt && !reqValid && (credits >= 3'd2);
	// a pending request still counts as beats to come
	assign drained = (outstanding == 3'd0) && !reqValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			haltSeen <= 1'b0;
		end else if (startIdle) begin
			busy <= 1'b1;
			haltSeen <= 1'b0;
		end else begin
			if (halt)
				haltSeen <= 1'b1;
			// run ends once the list stopped, DRAM is quiet and the queue is empty
			if (busy && haltSeen && drained && done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reqValid <= 1'b0;
		end else if (startIdle || canIssue) begin
			reqValid <= 1'b1;
		end else if (reqAccept || halt) begin
			reqValid <= 1'b0; // a stop withdraws an unaccepted request
		end
	end

	always_ff @(posedge clk) begin
		if (startIdle)
			reqAddr <= cmdAddr;
		else if (reqAccept)
			reqAddr <= reqAddr + 31'(`GP_ADDR_STEP);
	end

	always_ff @(posedge clk) begin
		if (rst || startIdle) begin
			credits <= 3'(`GP_BEAT_DEPTH); // buffer is empty at every start
		end else begin
			credits <= credits + {2'b00, beatCredit} - (reqAccept ? 3'd2 : 3'd0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 3'd0;
		else
			outstanding <= outstanding + (reqAccept ? 3'd2 : 3'd0) - {2'b00, rdValid};
	end

	creditBound: assert property (@(posedge clk) disable iff (rst)
		credits <= 3'(`GP_BEAT_DEPTH))
		else $error("beat credits above buffer depth");

	noStrayBeat: assert property (@(posedge clk) disable iff (rst)
		rdValid |-> (outstanding != 3'd0))
		else $error("read beat arrived with nothing outstanding");

endmodule

/* verilog/cmdUnpack.sv */
`include "gp_consts.svh"

module cmdUnpack (
	input  logic            clk,
	input  logic            rst,
	input  logic            rdValid,
	input  logic [127:0]    rdData,
	input  logic            wordTaken,
	input  logic            halt,
	input  logic            drained,
	output logic            beatCredit,
	output logic            wordValid,
	output gpPkg::cmdWord_u word
);
	localparam int PtrW = $clog2(`GP_BEAT_DEPTH);

	logic [127:0]    beatMem [`GP_BEAT_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0]   count;
	logic [1:0]      wordIdx; // word within the head beat
	logic            discard; // set by a stop until DRAM has drained
	logic            storeBeat;
	logic            dropBeat;
	logic            popBeat;

	assign storeBeat = rdValid && !discard && !halt;
	assign dropBeat = rdValid && (discard || halt);
	assign popBeat = wordValid && wordTaken && (wordIdx == 2'd3);

	assign wordValid = (count != '0);
	assign word = beatMem[rdPtr][32*wordIdx +: 32]; // low word first

	always_ff @(posedge clk) begin
		if (storeBeat)
			beatMem[wrPtr] <= rdData;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			wordIdx <= 2'd0;
			discard <= 1'b0;
			beatCredit <= 1'b0;
		end else begin
			// dropped beats still hand their slot back to fetch
			beatCredit <= popBeat || dropBeat;
			if (halt) begin
				rdPtr <= wrPtr; // flush whatever is left
				count <= '0;
				wordIdx <= 2'd0;
				discard <= 1'b1;
			end else begin
				if (storeBeat)
					wrPtr <= wrPtr + 1'b1;
				if (popBeat)
					rdPtr <= rdPtr + 1'b1;
				if (wordValid && wordTaken)
					wordIdx <= wordIdx + 2'd1;
				count <= count + {{PtrW{1'b0}}, storeBeat} - {{PtrW{1'b0}}, popBeat};
				if (drained)
					discard <= 1'b0;
			end
		end
	end

	noOverflow: assert property (@(posedge clk) disable iff (rst)
		storeBeat |-> ((count < `GP_BEAT_DEPTH) || popBeat))
		else $error("beat buffer overflow");

endmodule

/* verilog/engineDispatch.sv */
`include "gp_consts.svh"

module engineDispatch (
	input  logic            clk,
	input  logic            rst,
	input  logic            lineValid,
	input  gpPkg::lineCmd_t lineCmd,
	input  logic            fillValid,
	input  gpPkg::fillCmd_t fillCmd,
	input  logic            leCredit,
	input  logic            ffCredit,
	output logic            slotCredit,
	output logic            done,
	output logic            leValid,
	output gpPkg::lineCmd_t leCmd,
	output logic            ffValid,
	output gpPkg::fillCmd_t ffCmd
);
	import gpPkg::*;

	localparam int PtrW = $clog2(`GP_SLOT_CREDITS);

	lineCmd_t        lineQ [`GP_SLOT_CREDITS];
	fillCmd_t        fillQ [`GP_SLOT_CREDITS];
	logic            isLineQ [`GP_SLOT_CREDITS]; // entry tag
	logic [PtrW-1:0] head;
	logic [PtrW-1:0] tail;
	logic [PtrW:0]   count;
	logic [2:0]      leCreds;
	logic [2:0]      ffCreds;
	logic            enq;
	logic            pop;
	logic            headIsLine;

	assign enq = lineValid || fillValid;
	assign headIsLine = isLineQ[head];

	// only the head may leave, so order holds across both engines
	assign leValid = (count != '0) && headIsLine && (leCreds != 3'd0);
	assign ffValid = (count != '0) && !headIsLine && (ffCreds != 3'd0);
	assign leCmd = lineQ[head];
	assign ffCmd = fillQ[head];
	assign pop = leValid || ffValid;
	assign done = (count == '0);

	always_ff @(posedge clk) begin
		if (enq) begin
			isLineQ[tail] <= lineValid;
			lineQ[tail] <= lineCmd;
			fillQ[tail] <= fillCmd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			slotCredit <= 1'b0;
			leCreds <= 3'(`GP_LE_CREDITS);
			ffCreds <= 3'(`GP_FF_CREDITS);
		end else begin
			slotCredit <= pop; // freed entry goes back to decode
			if (enq)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			count <= count + {{PtrW{1'b0}}, enq} - {{PtrW{1'b0}}, pop};
			leCreds <= leCreds + {2'b00, leCredit} - {2'b00, leValid};
			ffCreds <= ffCreds + {2'b00, ffCredit} - {2'b00, ffValid};
		end
	end

	leCreditBound: assert property (@(posedge clk) disable iff (rst)
		leCreds <= 3'(`GP_LE_CREDITS))
		else $error("line engine returned more credits than it granted");

	ffCreditBound: assert property (@(posedge clk) disable iff (rst)
		ffCreds <= 3'(`GP_FF_CREDITS))
		else $error("frame filler returned more credits than it granted");

endmodule

/* verilog/gpPkg.sv */
package gpPkg;

	// opcode word, colour in the low three bytes
	typedef struct packed {
		logic [7:0]  op;
		logic [23:0] color;
	} fillView_t;

	// point word, x in 25:16 and y in 9:0
	typedef struct packed {
		logic [5:0] padHi;
		logic [9:0] x;
		logic [5:0] padLo;
		logic [9:0] y;
	} pointView_t;

	// one 32-bit list word, read as opcode or as point depending on decode state
	typedef union packed {
		fillView_t  fill;
		pointView_t point;
	} cmdWord_u;

	// frame filler command, 56 bits
	typedef struct packed {
		logic [23:0] color;
		logic [31:0] frame;
	} fillCmd_t;

	// line engine command, 96 bits
	typedef struct packed {
		logic [23:0] color;
		logic [9:0]  x0;
		logic [9:0]  y0;
		logic [9:0]  x1;
		logic [9:0]  y1;
		logic [31:0] frame;
	} lineCmd_t;

endpackage

/* verilog/graphicsCommandProcessor.sv */
module graphicsCommandProcessor (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  logic [30:0]     cmdAddr,
	input  logic [31:0]     frameBase,
	output logic            busy,
	output logic            reqValid,
	output logic [30:0]     reqAddr,
	input  logic            reqFull,
	input  logic            rdValid,
	input  logic [127:0]    rdData,
	output logic            leValid,
	output gpPkg::lineCmd_t leCmd,
	input  logic            leCredit,
	output logic            ffValid,
	output gpPkg::fillCmd_t ffCmd,
	input  logic            ffCredit
);
	import gpPkg::*;

	logic     startIdle; // frame is latched only for an accepted start
	logic     beatCredit;
	logic     drained;
	logic     halt;
	logic     done;
	logic     wordValid;
	logic     wordTaken;
	cmdWord_u word;
	logic     lineValid;
	lineCmd_t lineCmd;
	logic     fillValid;
	fillCmd_t fillCmd;
	logic     slotCredit;

	assign startIdle = start && !busy;

	cmdFetch fetch (
		.clk(clk),
		.rst(rst),
		.start(start),
		.cmdAddr(cmdAddr),
		.reqFull(reqFull),
		.rdValid(rdValid),
		.beatCredit(beatCredit),
		.halt(halt),
		.done(done),
		.reqValid(reqValid),
		.reqAddr(reqAddr),
		.drained(drained),
		.busy(busy)
	);

	cmdUnpack unpack (
		.clk(clk),
		.rst(rst),
		.rdValid(rdValid),
		.rdData(rdData),
		.wordTaken(wordTaken),
		.halt(halt),
		.drained(drained),
		.beatCredit(beatCredit),
		.wordValid(wordValid),
		.word(word)
	);

	cmdDecode decode (
		.clk(clk),
		.rst(rst),
		.start(startIdle),
		.frameBase(frameBase),
		.wordValid(wordValid),
		.word(word),
		.slotCredit(slotCredit),
		.wordTaken(wordTaken),
		.halt(halt),
		.lineValid(lineValid),
		.lineCmd(lineCmd),
		.fillValid(fillValid),
		.fillCmd(fillCmd)
	);

	engineDispatch dispatch (
		.clk(clk),
		.rst(rst),
		.lineValid(lineValid),
		.lineCmd(lineCmd),
		.fillValid(fillValid),
		.fillCmd(fillCmd),
		.leCredit(leCredit),
		.ffCredit(ffCredit),
		.slotCredit(slotCredit),
		.done(done),
		.leValid(leValid),
		.leCmd(leCmd),
		.ffValid(ffValid),
		.ffCmd(ffCmd)
	);

endmodule
